/* src/mcfifo_pkg.sv */
`default_nettype none

package mcfifo_pkg;

    localparam int NUM_CHANNELS      = 4;     // Channels 1 to 4
    localparam int WORD_BITS         = 32;
    localparam int BE_BITS           = 4;
    localparam int CHANNEL_BITS      = 8;     // Tag byte of a pattern word
    localparam int SEQ_BITS          = WORD_BITS - CHANNEL_BITS;
    localparam int PACKET_WORDS      = 16;    // Longest burst
    localparam int BUF_WORDS         = 2 * PACKET_WORDS;
    localparam int BUF_ADDR_BITS     = $clog2(BUF_WORDS);
    localparam int BUF_COUNT_BITS    = $clog2(BUF_WORDS + 1);
    localparam int BURST_BITS        = $clog2(PACKET_WORDS);
    localparam int RESET_WAIT_CYCLES = 20;
    localparam int RESET_WAIT_BITS   = $clog2(RESET_WAIT_CYCLES);

    // Command codes carried on be during the command word
    localparam logic [BE_BITS-1:0] CMD_HOST_READ  = 4'h0;
    localparam logic [BE_BITS-1:0] CMD_HOST_WRITE = 4'h1;

    // Idle drives only the status byte, bits 15..8
    localparam logic [WORD_BITS-1:0] STATUS_OE_N = 32'hFFFF_00FF;

    localparam int STATE_BITS = 4;
    localparam logic [STATE_BITS-1:0] ST_RESET      = 4'd0;
    localparam logic [STATE_BITS-1:0] ST_IDLE       = 4'd1;
    localparam logic [STATE_BITS-1:0] ST_READ_BTA1  = 4'd2;
    localparam logic [STATE_BITS-1:0] ST_READ_BTA2  = 4'd3;
    localparam logic [STATE_BITS-1:0] ST_READ_DATA  = 4'd4;
    localparam logic [STATE_BITS-1:0] ST_READ_BTA3  = 4'd5;
    localparam logic [STATE_BITS-1:0] ST_WRITE_BTA1 = 4'd6;
    localparam logic [STATE_BITS-1:0] ST_WRITE_DATA = 4'd7;
    localparam logic [STATE_BITS-1:0] ST_WRITE_BTA2 = 4'd8;

    // One bus word, read as a command or written as the idle status
    typedef union packed {
        struct packed {
            logic [WORD_BITS-CHANNEL_BITS-1:0] upper;
            logic [CHANNEL_BITS-1:0]           channel;
        } cmd;
        struct packed {
            logic [WORD_BITS-17:0]    zero_hi;
            logic [NUM_CHANNELS-1:0]  rx_space_n;   // Channel 1 in bit 12
            logic [NUM_CHANNELS-1:0]  tx_req_n;     // Channel 1 in bit 8
            logic [7:0]               zero_lo;
        } status;
    } bus_word_u;

endpackage

`default_nettype wire

/* src/mcfifo_tx_buf.sv */
`default_nettype none

module mcfifo_tx_buf import mcfifo_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 push,
    input  logic [WORD_BITS-1:0] push_data,
    input  logic                 pop,
    output logic [WORD_BITS-1:0] head,
    output logic                 tx_ready,
    output logic                 full
);

    logic [WORD_BITS-1:0]      mem [BUF_WORDS];
    logic [BUF_ADDR_BITS-1:0]  wr_ptr;
    logic [BUF_ADDR_BITS-1:0]  rd_ptr;
    logic [BUF_COUNT_BITS-1:0] count;
    logic                      do_push;
    logic                      do_pop;

    assign full     = (count == BUF_COUNT_BITS'(BUF_WORDS));
    assign tx_ready = (count >= BUF_COUNT_BITS'(PACKET_WORDS));   // Whole packet waiting
    assign head     = mem[rd_ptr];                                // Fall-through head

    assign do_push = push && !full;
    assign do_pop  = pop && (count != '0);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;     // Wraps at BUF_WORDS
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/mcfifo_rx_buf.sv */
`default_nettype none

module mcfifo_rx_buf import mcfifo_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 push,
    input  logic [WORD_BITS-1:0] push_data,
    input  logic [BE_BITS-1:0]   push_be,
    input  logic                 pop,
    output logic [WORD_BITS-1:0] head,
    output logic [BE_BITS-1:0]   head_be,
    output logic                 empty,
    output logic                 rx_space
);

    logic [WORD_BITS-1:0]      mem [BUF_WORDS];
    logic [BE_BITS-1:0]        mem_be [BUF_WORDS];
    logic [BUF_ADDR_BITS-1:0]  wr_ptr;
    logic [BUF_ADDR_BITS-1:0]  rd_ptr;
    logic [BUF_COUNT_BITS-1:0] count;
    logic                      do_push;
    logic                      do_pop;

    assign empty    = (count == '0);
    assign rx_space = (count <= BUF_COUNT_BITS'(BUF_WORDS - PACKET_WORDS));   // Room for a packet
    assign head     = mem[rd_ptr];
    assign head_be  = mem_be[rd_ptr];

    assign do_push = push && (count != BUF_COUNT_BITS'(BUF_WORDS));
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr]    <= push_data;
            mem_be[wr_ptr] <= push_be;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/mcfifo_data_source.sv */
`default_nettype none

module mcfifo_data_source import mcfifo_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [CHANNEL_BITS-1:0] channel_id,
    input  logic                    full,
    output logic                    push,
    output logic [WORD_BITS-1:0]    push_data
);

    logic [SEQ_BITS-1:0] seq;    // k of the next word

    // Offer a word whenever the buffer can take one
    assign push      = !full;
    assign push_data = {channel_id, seq};

    always_ff @(posedge clk) begin
        if (reset) begin
            seq <= '0;
        end else if (push) begin
            seq <= seq + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/mcfifo_data_sink.sv */
`default_nettype none

module mcfifo_data_sink import mcfifo_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [CHANNEL_BITS-1:0] channel_id,
    input  logic                    empty,
    input  logic [WORD_BITS-1:0]    head,
    input  logic [BE_BITS-1:0]      head_be,
    output logic                    pop,
    output logic                    error
);

    logic [SEQ_BITS-1:0]  expected_seq;
    logic [WORD_BITS-1:0] expected_word;
    logic                 mismatch;

    assign pop           = !empty;                    // Drain one word per cycle
    assign expected_word = {channel_id, expected_seq};
    assign mismatch      = (head != expected_word) || (head_be != '1);

    always_ff @(posedge clk) begin
        if (reset) begin
            expected_seq <= '0;
            error        <= 1'b0;
        end else if (pop) begin
            expected_seq <= expected_seq + 1'b1;     // Advances even past a bad word
            if (mismatch) begin
                error <= 1'b1;                       // Sticky until reset
            end
        end
    end

endmodule

`default_nettype wire

/* src/mcfifo_bus_fsm.sv */
`default_nettype none

module mcfifo_bus_fsm import mcfifo_pkg::*; (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 wr_n,
    input  logic [WORD_BITS-1:0]                 data_in,
    input  logic [BE_BITS-1:0]                   be_in,
    input  logic [NUM_CHANNELS:1][WORD_BITS-1:0] tx_head,
    input  logic [NUM_CHANNELS:1]                tx_ready,
    input  logic [NUM_CHANNELS:1]                rx_space,
    output logic [WORD_BITS-1:0]                 data_out,
    output logic [BE_BITS-1:0]                   be_out,
    output logic [WORD_BITS-1:0]                 data_oe_n,
    output logic [BE_BITS-1:0]                   be_oe_n,
    output logic                                 txe_n,
    output logic                                 rxf_n,
    output logic [NUM_CHANNELS:1]                tx_pop,
    output logic [NUM_CHANNELS:1]                rx_push,
    output logic [WORD_BITS-1:0]                 rx_data,
    output logic [BE_BITS-1:0]                   rx_be
);

    logic [STATE_BITS-1:0]      state;
    logic [RESET_WAIT_BITS-1:0] reset_count;
    logic [BURST_BITS-1:0]      burst_count;
    logic [NUM_CHANNELS:1]      ch_sel;        // Captured channel, one-hot
    logic [NUM_CHANNELS:1]      cmd_sel;
    logic [WORD_BITS-1:0]       head_sel;
    bus_word_u                  cmd_word;
    bus_word_u                  status_word;
    logic                       is_read;
    logic                       is_write;
    logic                       cmd_ok;
    logic                       burst_last;
    logic                       xfer;

    assign cmd_word = data_in;
    assign is_read  = (be_in == CMD_HOST_READ);
    assign is_write = (be_in == CMD_HOST_WRITE);

    // Channel numbers outside 1..4 leave cmd_sel empty
    always_comb begin
        cmd_sel = '0;
        for (int c = 1; c <= NUM_CHANNELS; c++) begin
            cmd_sel[c] = (cmd_word.cmd.channel == CHANNEL_BITS'(c));
        end
    end

    assign cmd_ok = (is_read && |(cmd_sel & tx_ready)) ||
                    (is_write && |(cmd_sel & rx_space));

    always_comb begin
        head_sel = '0;
        for (int c = 1; c <= NUM_CHANNELS; c++) begin
            if (ch_sel[c]) begin
                head_sel = tx_head[c];
            end
        end
    end

    always_comb begin
        status_word = '0;
        status_word.status.tx_req_n   = ~tx_ready;
        status_word.status.rx_space_n = ~rx_space;
    end

    assign data_out = (state == ST_READ_DATA) ? head_sel : status_word;
    assign be_out   = (state == ST_READ_DATA) ? '1 : '0;

    // One word moves on each edge with both strobes low
    assign xfer       = !wr_n && !rxf_n;
    assign burst_last = (burst_count == BURST_BITS'(PACKET_WORDS - 1));
    assign tx_pop     = ch_sel & {NUM_CHANNELS{xfer && (state == ST_READ_DATA)}};
    assign rx_push    = ch_sel & {NUM_CHANNELS{xfer && (state == ST_WRITE_DATA)}};
    assign rx_data    = data_in;
    assign rx_be      = be_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_RESET;
            reset_count <= '0;
            burst_count <= '0;
            ch_sel      <= '0;
            txe_n       <= 1'b1;
            rxf_n       <= 1'b1;
            data_oe_n   <= '1;
            be_oe_n     <= '1;
        end else begin
            case (state)
                ST_RESET: begin
                    if (reset_count == RESET_WAIT_BITS'(RESET_WAIT_CYCLES - 1)) begin
                        state     <= ST_IDLE;
                        txe_n     <= 1'b0;
                        data_oe_n <= STATUS_OE_N;
                    end else begin
                        reset_count <= reset_count + 1'b1;
                    end
                end
                ST_IDLE: begin
                    if (!wr_n && cmd_ok) begin
                        ch_sel      <= cmd_sel;
                        burst_count <= '0;
                        txe_n       <= 1'b1;
                        state       <= is_read ? ST_READ_BTA1 : ST_WRITE_BTA1;
                    end
                end
                ST_READ_BTA1: begin
                    data_oe_n <= '0;                // Device takes the whole bus
                    be_oe_n   <= '0;
                    state     <= ST_READ_BTA2;
                end
                ST_READ_BTA2: begin
                    rxf_n <= 1'b0;
                    state <= ST_READ_DATA;
                end
                ST_READ_DATA: begin
                    if (wr_n) begin                 // Host stopped early
                        rxf_n <= 1'b1;
                        state <= ST_READ_BTA3;
                    end else begin
                        burst_count <= burst_count + 1'b1;
                        if (burst_last) begin
                            rxf_n <= 1'b1;
                            state <= ST_READ_BTA3;
                        end
                    end
                end
                ST_READ_BTA3: begin
                    data_oe_n <= STATUS_OE_N;
                    be_oe_n   <= '1;
                    ch_sel    <= '0;
                    txe_n     <= 1'b0;
                    state     <= ST_IDLE;
                end
                ST_WRITE_BTA1: begin
                    data_oe_n <= '1;                // Hand the bus to the host
                    rxf_n     <= 1'b0;
                    state     <= ST_WRITE_DATA;
                end
                ST_WRITE_DATA: begin
                    if (wr_n) begin
                        rxf_n <= 1'b1;
                        state <= ST_WRITE_BTA2;
                    end else begin
                        burst_count <= burst_count + 1'b1;
                        if (burst_last) begin
                            rxf_n <= 1'b1;          // Further words are dropped
                            state <= ST_WRITE_BTA2;
                        end
                    end
                end
                ST_WRITE_BTA2: begin
                    data_oe_n <= STATUS_OE_N;
                    ch_sel    <= '0;
                    txe_n     <= 1'b0;
                    state     <= ST_IDLE;
                end
                default: begin
                    state <= ST_RESET;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/mcfifo_top.sv */
`default_nettype none

module mcfifo_top import mcfifo_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [WORD_BITS-1:0]  data_in,
    output logic [WORD_BITS-1:0]  data_out,
    output logic [WORD_BITS-1:0]  data_oe_n,
    input  logic [BE_BITS-1:0]    be_in,
    output logic [BE_BITS-1:0]    be_out,
    output logic [BE_BITS-1:0]    be_oe_n,
    input  logic                  wr_n,
    output logic                  txe_n,
    output logic                  rxf_n,
    output logic [NUM_CHANNELS:1] sink_error
);

    logic [NUM_CHANNELS:1]                src_push;
    logic [NUM_CHANNELS:1][WORD_BITS-1:0] src_data;
    logic [NUM_CHANNELS:1]                tx_full;
    logic [NUM_CHANNELS:1][WORD_BITS-1:0] tx_head;
    logic [NUM_CHANNELS:1]                tx_ready;
    logic [NUM_CHANNELS:1]                tx_pop;
    logic [NUM_CHANNELS:1]                rx_push;
    logic [NUM_CHANNELS:1]                rx_space;
    logic [NUM_CHANNELS:1]                rx_empty;
    logic [NUM_CHANNELS:1]                sink_pop;
    logic [NUM_CHANNELS:1][WORD_BITS-1:0] rx_head;
    logic [NUM_CHANNELS:1][BE_BITS-1:0]   rx_head_be;
    logic [WORD_BITS-1:0]                 rx_data;     // Shared by all receive buffers
    logic [BE_BITS-1:0]                   rx_be;

    for (genvar i = 1; i <= NUM_CHANNELS; i++) begin : g_lane
        mcfifo_data_source u_source (
            .clk(clk), .reset(reset), .channel_id(CHANNEL_BITS'(i)),
            .full(tx_full[i]), .push(src_push[i]), .push_data(src_data[i])
        );
        mcfifo_tx_buf u_tx_buf (
            .clk(clk), .reset(reset), .push(src_push[i]), .push_data(src_data[i]),
            .pop(tx_pop[i]), .head(tx_head[i]), .tx_ready(tx_ready[i]), .full(tx_full[i])
        );
        mcfifo_rx_buf u_rx_buf (
            .clk(clk), .reset(reset), .push(rx_push[i]), .push_data(rx_data),
            .push_be(rx_be), .pop(sink_pop[i]), .head(rx_head[i]),
            .head_be(rx_head_be[i]), .empty(rx_empty[i]), .rx_space(rx_space[i])
        );
        mcfifo_data_sink u_sink (
            .clk(clk), .reset(reset), .channel_id(CHANNEL_BITS'(i)),
            .empty(rx_empty[i]), .head(rx_head[i]), .head_be(rx_head_be[i]),
            .pop(sink_pop[i]), .error(sink_error[i])
        );
    end

    mcfifo_bus_fsm u_bus_fsm (
        .clk(clk), .reset(reset), .wr_n(wr_n), .data_in(data_in), .be_in(be_in),
        .tx_head(tx_head), .tx_ready(tx_ready), .rx_space(rx_space),
        .data_out(data_out), .be_out(be_out), .data_oe_n(data_oe_n), .be_oe_n(be_oe_n),
        .txe_n(txe_n), .rxf_n(rxf_n), .tx_pop(tx_pop), .rx_push(rx_push),
        .rx_data(rx_data), .rx_be(rx_be)
    );

endmodule

`default_nettype wire

/* verif/mcfifo_assertions.sv */
`default_nettype none

module mcfifo_assertions import mcfifo_pkg::*; (
    input logic                  clk,
    input logic                  reset,
    input logic                  txe_n,
    input logic                  rxf_n,
    input logic [NUM_CHANNELS:1] tx_pop,
    input logic [NUM_CHANNELS:1] rx_push
);

    // Data phase never overlaps idle
    rxf_only_when_busy: assert property (@(posedge clk) disable iff (reset)
        !rxf_n |-> txe_n)
        else $error("rxf_n low while txe_n low");

    one_direction: assert property (@(posedge clk) disable iff (reset)
        !((|tx_pop) && (|rx_push)))
        else $error("tx_pop and rx_push active together");

    single_pop: assert property (@(posedge clk) disable iff (reset)
        $onehot0(tx_pop))
        else $error("more than one tx_pop bit set");

endmodule

bind mcfifo_bus_fsm mcfifo_assertions u_assertions (
    .clk(clk), .reset(reset), .txe_n(txe_n), .rxf_n(rxf_n),
    .tx_pop(tx_pop), .rx_push(rx_push)
);

`default_nettype wire

/* verif/mcfifo_tb_host.svh */
`ifndef MCFIFO_TB_HOST_SVH
`define MCFIFO_TB_HOST_SVH

// Host tasks start and end on a falling edge

function automatic bus_word_u pattern_word(input int ch, input int k);
    bus_word_u w;
    w = {ch[CHANNEL_BITS-1:0], k[SEQ_BITS-1:0]};    // Channel tag over sequence
    return w;
endfunction

task automatic shuffle_channels();
    int j;
    int t;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
        channel_order[c] = c + 1;
    end
    for (int i = NUM_CHANNELS - 1; i > 0; i--) begin
        j                = ($random(seed) & 32'h7FFF_FFFF) % (i + 1);
        t                = channel_order[i];
        channel_order[i] = channel_order[j];
        channel_order[j] = t;
    end
endtask

task automatic drive_idle();
    wr_n    = 1'b1;
    data_in = '0;
    be_in   = '0;
endtask

// One command word, held for a single rising edge
task automatic send_command(input int ch, input logic [BE_BITS-1:0] code);
    bus_word_u cmd;
    cmd             = '0;
    cmd.cmd.channel = ch[CHANNEL_BITS-1:0];
    wr_n            = 1'b0;
    data_in         = cmd;
    be_in           = code;
    @(posedge clk);
    @(negedge clk);
    drive_idle();
endtask

task automatic wait_rxf(input logic level);
    int cycles;
    cycles = 0;
    while (rxf_n !== level) begin
        if (cycles == TIMEOUT_CYCLES) begin
            report_timeout("rxf_n to change");
        end
        @(negedge clk);
        cycles++;
    end
endtask

task automatic wait_txe_low();
    int cycles;
    cycles = 0;
    while (txe_n !== 1'b0) begin
        if (cycles == TIMEOUT_CYCLES) begin
            report_timeout("txe_n low");
        end
        @(negedge clk);
        cycles++;
    end
endtask

task automatic stay_idle();
    bus_word_u ready;
    ready = '0;                          // Every channel has a packet and space
    repeat (QUIET_CYCLES) begin
        check_bit("txe_n", 1'b0, txe_n);
        check_bit("rxf_n", 1'b1, rxf_n);
        check_status(ready, data_out);
        @(negedge clk);
    end
endtask

task automatic read_burst(input int ch, input int words);
    wait_txe_low();
    send_command(ch, CMD_HOST_READ);
    wait_rxf(1'b0);
    for (int i = 0; i < words; i++) begin
        check_bit("rxf_n", 1'b0, rxf_n);
        check_word(pattern_word(ch, rd_k[ch]), data_out);
        check_word('0, data_oe_n);       // Device owns the whole bus
        check_be("be_oe_n", '0, be_oe_n);
        check_be("be_out", '1, be_out);
        wr_n     = 1'b0;                 // Word moves on the next edge
        rd_k[ch] = rd_k[ch] + 1;
        @(posedge clk);
        @(negedge clk);
    end
    wr_n = 1'b1;
    if (words == PACKET_WORDS) begin
        check_bit("rxf_n", 1'b1, rxf_n);
    end
    wait_txe_low();
    check_word(STATUS_OE_N, data_oe_n);
    check_be("be_oe_n", '1, be_oe_n);
endtask

task automatic write_burst(input int ch, input int words, input int bad_index);
    wait_txe_low();
    send_command(ch, CMD_HOST_WRITE);
    wait_rxf(1'b0);
    for (int i = 0; i < words; i++) begin
        check_bit("rxf_n", i >= PACKET_WORDS, rxf_n);    // Past one packet is refused
        check_be("be_oe_n", '1, be_oe_n);
        if (i < PACKET_WORDS) begin
            check_word('1, data_oe_n);                   // Bus belongs to the host
        end
        data_in = pattern_word(ch, wr_k[ch] + i);
        if (i == bad_index) begin
            data_in[0] = ~data_in[0];
        end
        be_in = '1;
        wr_n  = 1'b0;
        @(posedge clk);
        @(negedge clk);
    end
    drive_idle();
    wr_k[ch] = wr_k[ch] + ((words < PACKET_WORDS) ? words : PACKET_WORDS);
    wait_txe_low();
endtask

`endif

/* verif/mcfifo_tb.sv */
`default_nettype none

module mcfifo_tb import mcfifo_pkg::*; ();

    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int QUIET_CYCLES   = 40;     // Window for ignored commands
    localparam int OVER_OFFER     = 20;     // Longer than one packet

    logic                  clk;
    logic                  reset;
    logic [WORD_BITS-1:0]  data_in;
    logic [WORD_BITS-1:0]  data_out;
    logic [WORD_BITS-1:0]  data_oe_n;
    logic [BE_BITS-1:0]    be_in;
    logic [BE_BITS-1:0]    be_out;
    logic [BE_BITS-1:0]    be_oe_n;
    logic                  wr_n;
    logic                  txe_n;
    logic                  rxf_n;
    logic [NUM_CHANNELS:1] sink_error;

    integer seed;
    string  test_name;
    int     rd_k [NUM_CHANNELS:1];          // Next k expected from the device
    int     wr_k [NUM_CHANNELS:1];          // Next k sent to the device
    int     channel_order [NUM_CHANNELS];

    mcfifo_top u_dut (
        .clk(clk), .reset(reset), .data_in(data_in), .data_out(data_out),
        .data_oe_n(data_oe_n), .be_in(be_in), .be_out(be_out), .be_oe_n(be_oe_n),
        .wr_n(wr_n), .txe_n(txe_n), .rxf_n(rxf_n), .sink_error(sink_error)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic end_with_failure();
        $display(">>> FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in %s while waiting for %s", test_name, what);
        end_with_failure();
    endtask

    task automatic check_word(input bus_word_u expected, input bus_word_u actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", test_name, expected, actual);
            end_with_failure();
        end
    endtask

    // Only the status byte is driven while idle
    task automatic check_status(input bus_word_u expected, input bus_word_u actual);
        if ({actual.status.rx_space_n, actual.status.tx_req_n} !==
            {expected.status.rx_space_n, expected.status.tx_req_n}) begin
            $display("Fail %s: expected status %h, actual status %h", test_name,
                     {expected.status.rx_space_n, expected.status.tx_req_n},
                     {actual.status.rx_space_n, actual.status.tx_req_n});
            end_with_failure();
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s: %s expected %b, actual %b", test_name, what, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_be(input string what, input logic [BE_BITS-1:0] expected,
                            input logic [BE_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: %s expected %h, actual %h", test_name, what, expected, actual);
            end_with_failure();
        end
    endtask

    `include "mcfifo_tb_host.svh"

    task automatic after_reset_state();
        bus_word_u ready;
        bus_word_u seen;
        int        cycles;
        test_name = "after_reset";
        ready     = '0;                      // Every channel has a packet and space
        cycles    = 0;
        while (txe_n) begin
            check_bit("rxf_n", 1'b1, rxf_n);
            check_word(32'hFFFF_FFFF, data_oe_n);
            check_be("be_oe_n", '1, be_oe_n);
            if (cycles == TIMEOUT_CYCLES) begin
                report_timeout("txe_n low after reset");
            end
            @(negedge clk);
            cycles++;
        end
        if (cycles < RESET_WAIT_CYCLES) begin
            $display("txe_n fell after %0d cycles, before the reset wait ended", cycles);
            end_with_failure();
        end
        cycles = 0;
        seen   = data_out;
        while (seen.status.tx_req_n != '0 || seen.status.rx_space_n != '0) begin
            if (cycles == TIMEOUT_CYCLES) begin
                report_timeout("all channels ready");
            end
            @(negedge clk);
            cycles++;
            seen = data_out;
        end
        check_word(ready, seen);             // Bits outside the status byte are zero
        check_word(STATUS_OE_N, data_oe_n);
        for (int c = 1; c <= NUM_CHANNELS; c++) begin
            check_bit("sink_error", 1'b0, sink_error[c]);
        end
    endtask

    task automatic read_each_channel();
        test_name = "read_bursts";
        shuffle_channels();
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            read_burst(channel_order[i], PACKET_WORDS);
            read_burst(channel_order[i], PACKET_WORDS);    // Sequence carries over
        end
    endtask

    task automatic read_with_early_stop();
        int ch;
        int words;
        test_name = "read_early_stop";
        shuffle_channels();
        ch    = channel_order[0];
        words = 1 + (($random(seed) & 32'h7FFF_FFFF) % (PACKET_WORDS - 1));
        read_burst(ch, words);
        read_burst(ch, PACKET_WORDS);
    endtask

    task automatic write_each_channel();
        test_name = "write_bursts";
        shuffle_channels();
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            write_burst(channel_order[i], PACKET_WORDS, -1);
        end
        write_burst(channel_order[0], OVER_OFFER, -1);     // Only one packet taken
        write_burst(channel_order[0], PACKET_WORDS, -1);
        @(negedge clk);                                    // Sink trails by one cycle
        for (int c = 1; c <= NUM_CHANNELS; c++) begin
            check_bit("sink_error", 1'b0, sink_error[c]);
        end
    endtask

    task automatic ignore_bad_commands();
        test_name = "bad_commands";
        wait_txe_low();
        send_command(0, CMD_HOST_READ);
        stay_idle();
        send_command(NUM_CHANNELS + 1, CMD_HOST_WRITE);
        stay_idle();
        send_command(1, 4'h2);
        stay_idle();
    endtask

    task automatic flag_bad_word();
        int ch;
        int bad;
        test_name = "bad_word";
        shuffle_channels();
        ch  = channel_order[0];
        bad = ($random(seed) & 32'h7FFF_FFFF) % PACKET_WORDS;
        write_burst(ch, PACKET_WORDS, bad);
        @(negedge clk);
        for (int c = 1; c <= NUM_CHANNELS; c++) begin
            check_bit("sink_error", c == ch, sink_error[c]);
        end
    endtask

    initial begin
        seed      = 13;
        reset     = 1'b1;
        wr_n      = 1'b1;
        data_in   = '0;
        be_in     = '0;
        test_name = "reset";
        for (int c = 1; c <= NUM_CHANNELS; c++) begin
            rd_k[c] = 0;
            wr_k[c] = 0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        after_reset_state();
        read_each_channel();
        read_with_early_stop();
        write_each_channel();
        ignore_bad_commands();
        flag_bad_word();                 // Sticky error, so it runs last
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* mcfifo_top.f */
+incdir+verif
src/mcfifo_pkg.sv
src/mcfifo_tx_buf.sv
src/mcfifo_rx_buf.sv
src/mcfifo_data_source.sv
src/mcfifo_data_sink.sv
src/mcfifo_bus_fsm.sv
src/mcfifo_top.sv
verif/mcfifo_assertions.sv
verif/mcfifo_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module mcfifo_tb \
    -f mcfifo_top.f \
    --Mdir obj_dir -o mcfifo_sim

./obj_dir/mcfifo_sim
